//--- alu8.sv
module alu8 (
	input isa_pkg::alu_op_e op,
	input bus_pkg::data_t a_in, b_in,
	input logic carry_in,
	output bus_pkg::data_t result,
	output logic [3:0] flags
);
	import isa_pkg::*;
	import bus_pkg::*;

	data_t opnd;		// Second operand, 1 for INC/DEC
	logic cin;			// Carry or borrow in
	logic sub_op;
	logic [8:0] sum;	// Bit 8 is carry or borrow out of bit 7
	logic [4:0] half;	// Bit 4 is carry or borrow out of bit 3
	logic fl_n, fl_h, fl_c;

	always_comb
	begin
		opnd = (op inside {inc, dec}) ? 8'h01 : b_in;
		cin = (op inside {adc, sbc}) ? carry_in : 1'b0;
		sub_op = op inside {sub, sbc, cp, dec};
		if (sub_op)
		begin
			sum = {1'b0, a_in} - {1'b0, opnd} - {8'h00, cin};
			half = {1'b0, a_in[3:0]} - {1'b0, opnd[3:0]} - {4'h0, cin};
		end
		else
		begin
			sum = {1'b0, a_in} + {1'b0, opnd} + {8'h00, cin};
			half = {1'b0, a_in[3:0]} + {1'b0, opnd[3:0]} + {4'h0, cin};
		end

		// Arithmetic defaults, logic ops override below
		result = sum[7:0];
		fl_n = sub_op;
		fl_h = half[4];
		fl_c = sum[8];
		case (op)
			and_op:
			begin
				result = a_in & opnd;
				fl_h = 1'b1;
				fl_c = 1'b0;
			end
			xor_op:
			begin
				result = a_in ^ opnd;
				fl_h = 1'b0;
				fl_c = 1'b0;
			end
			or_op:
			begin
				result = a_in | opnd;
				fl_h = 1'b0;
				fl_c = 1'b0;
			end
			cpl:
			begin
				result = ~a_in;
				fl_n = 1'b1;
				fl_h = 1'b1;
				fl_c = carry_in;
			end
			inc, dec: fl_c = carry_in;	// C unchanged
			default: ;
		endcase

		flags[flag_z] = (result == 8'h00);
		flags[flag_n] = fl_n;
		flags[flag_h] = fl_h;
		flags[flag_c] = fl_c;
	end

endmodule

//--- bus_pkg.sv
package bus_pkg;

	typedef logic [15:0] addr_t;
	typedef logic [7:0] data_t;

	// Kind of memory machine cycle
	typedef enum logic [1:0] {
		fetch_op, fetch_imm, read_mem, write_mem
	} mcycle_e;

	// The four clocks of one machine cycle
	typedef enum logic [1:0] {
		ph_addr, ph_strobe, ph_capture, ph_release
	} phase_e;

endpackage

//--- bus_sequencer.sv
module bus_sequencer (
	input logic clk, reset,
	input bus_pkg::data_t din,
	output bus_pkg::addr_t adr,
	output bus_pkg::data_t dout,
	output logic ddrv, read, write,
	cpu_bus_if.seq bus
);
	import bus_pkg::*;

	phase_e phase;	// Free running, one step per clock
	mcycle_e kind;	// Kind of the cycle in flight
	data_t rdata;	// Captured read byte

	assign bus.phase = phase;
	assign bus.rdata = rdata;

	// ----------------------------------------
	// Phase counter and strobes
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			phase <= ph_addr;
			ddrv <= 1'b0;
			read <= 1'b0;
			write <= 1'b0;
		end
		else
		begin
			phase <= phase_e'(phase + 2'd1);	// Wraps back to ph_addr
			case (phase)
				ph_addr: ddrv <= (bus.kind == write_mem);	// Release data bus for reads
				ph_strobe:
				begin
					read <= (kind != write_mem);
					write <= (kind == write_mem);
				end
				ph_capture: write <= 1'b0;	// Write pulse is one clock
				ph_release: read <= 1'b0;
				default: ;
			endcase
		end
	end

	// ----------------------------------------
	// Address, data out and captured byte
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (phase == ph_addr)
		begin
			kind <= bus.kind;
			adr <= bus.adr;
			if (bus.kind == write_mem)
				dout <= bus.wdata;
		end
		if ((phase == ph_capture) && (kind != write_mem))
			rdata <= din;	// Memory answers while read is high
	end

endmodule

//--- cpu_bus_if.sv
interface cpu_bus_if;
	import bus_pkg::*;

	mcycle_e kind;	// Next cycle kind, valid at ph_addr
	addr_t adr;		// Next cycle address
	data_t wdata;	// Store byte for write_mem
	phase_e phase;	// Current clock of the machine cycle
	data_t rdata;	// Byte captured at ph_capture

	modport ctrl (
		output kind, adr, wdata,
		input phase, rdata
	);

	modport seq (
		input kind, adr, wdata,
		output phase, rdata
	);

endinterface

//--- cpu_control.sv
module cpu_control #(
	parameter bus_pkg::addr_t reset_pc = 16'h0000	// First fetch address
) (
	input logic clk, reset,
	cpu_bus_if.ctrl bus,
	output logic wr_en,
	output isa_pkg::reg_idx_e wr_sel,
	output bus_pkg::data_t wr_data,
	output logic pair_wr_en,
	output logic [1:0] pair_sel,
	output bus_pkg::addr_t pair_data,
	output isa_pkg::reg_idx_e rd_sel_src, rd_sel_dst,
	input bus_pkg::data_t src, dst, acc,
	input bus_pkg::addr_t hl,
	output isa_pkg::alu_op_e alu_op,
	output bus_pkg::data_t alu_a, alu_b,
	output logic alu_carry,
	input bus_pkg::data_t alu_result,
	input logic [3:0] alu_flags,
	output bus_pkg::addr_t pc,
	output logic [3:0] f
);
	import isa_pkg::*;
	import bus_pkg::*;

	typedef enum logic [2:0] {
		ifetch, imml_fetch, immh_fetch, mem_read, mem_write, jump
	} state_e;

	state_e state, next_state;
	data_t op, imml, immh;	// Opcode and immediate latches
	data_t opc;				// Opcode under decode
	op_group_e grp;
	logic src_mem, dst_mem;	// Field selects (HL)
	logic taken, exec, release_ph;
	addr_t add16;
	logic [3:0] f_next;

	assign release_ph = (bus.phase == ph_release);
	assign opc = (state == ifetch) ? bus.rdata : op;	// Opcode byte is live at ifetch commit
	assign src_mem = (opc[2:0] == 3'd6);
	assign dst_mem = (opc[5:3] == 3'd6);
	assign rd_sel_src = reg_idx_e'(opc[2:0]);
	assign rd_sel_dst = reg_idx_e'(opc[5:3]);

	// Unconditional JP has op[0] set, unconditional JR op[5] clear
	assign taken = ((grp == grp_jp) ? opc[0] : !opc[5])
		|| ((opc[4] ? f[flag_c] : f[flag_z]) == opc[3]);
	// PC+1 at ph_strobe, PC+e8 at a JR commit
	assign add16 = pc + ((bus.phase == ph_strobe) ? 16'd1 : {{8{imml[7]}}, imml});

	// ----------------------------------------
	// Decode
	// ----------------------------------------
	always_comb
	begin
		casez (opc)
			8'h34, 8'h35, 8'h76: grp = grp_nop;	// (HL) INC/DEC, HALT
			8'h18, 8'h20, 8'h28, 8'h30, 8'h38: grp = grp_jr;
			8'hc2, 8'hc3, 8'hca, 8'hd2, 8'hda: grp = grp_jp;
			8'h2f: grp = grp_cpl;
			8'h37: grp = grp_scf;
			8'h3f: grp = grp_ccf;
			8'b00??_0001: grp = grp_ld_rr_d16;
			8'b00??_?110: grp = grp_ld_r_d8;
			8'b00??_?10?: grp = grp_inc_dec;
			8'b01??_????: grp = grp_ld_r_r;
			8'b10??_????: grp = grp_alu_r;
			8'b11??_?110: grp = grp_alu_d8;
			default: grp = grp_nop;
		endcase
		case (grp)
			grp_inc_dec: alu_op = opc[0] ? dec : inc;
			grp_cpl: alu_op = cpl;
			default: alu_op = alu_op_e'({1'b0, opc[5:3]});	// Bits 5:3 pick the op
		endcase
	end

	assign alu_a = (grp == grp_inc_dec) ? dst : acc;
	assign alu_b = ((state == imml_fetch) || (state == mem_read)) ? bus.rdata : src;
	assign alu_carry = f[flag_c];

	// ----------------------------------------
	// Bus requests for the next cycle
	// ----------------------------------------
	always_comb
	begin
		case (state)
			ifetch: bus.kind = fetch_op;
			imml_fetch, immh_fetch: bus.kind = fetch_imm;
			mem_write: bus.kind = write_mem;
			default: bus.kind = read_mem;	// (HL) read, or idle read at PC in jump
		endcase
	end

	assign bus.adr = ((state == mem_read) || (state == mem_write)) ? hl : pc;
	assign bus.wdata = src;	// LD (HL),r

	// ----------------------------------------
	// Sequencing and commit
	// ----------------------------------------
	always_comb
	begin
		next_state = ifetch;
		case (state)
			ifetch:
			begin
				if (grp inside {grp_ld_r_d8, grp_ld_rr_d16, grp_alu_d8, grp_jp, grp_jr})
					next_state = imml_fetch;
				else if ((grp inside {grp_ld_r_r, grp_alu_r}) && src_mem)
					next_state = mem_read;
				else if ((grp == grp_ld_r_r) && dst_mem)
					next_state = mem_write;
			end
			imml_fetch:
			begin
				if (grp inside {grp_ld_rr_d16, grp_jp})
					next_state = immh_fetch;
				else if ((grp == grp_jr) && taken)
					next_state = jump;
			end
			immh_fetch:
				if ((grp == grp_jp) && taken)
					next_state = jump;
			default: ;
		endcase
	end

	// Last machine cycle of the instruction
	assign exec = release_ph && (next_state == ifetch) && (state != mem_write);

	always_comb
	begin
		wr_en = 1'b0;
		wr_sel = rd_sel_dst;
		wr_data = alu_b;	// Plain loads pass the operand
		pair_wr_en = 1'b0;
		pair_sel = opc[5:4];
		pair_data = {bus.rdata, imml};	// High byte arrives last
		f_next = f;
		if (exec)
		begin
			case (grp)
				grp_ld_r_r, grp_ld_r_d8: wr_en = 1'b1;
				grp_ld_rr_d16: pair_wr_en = 1'b1;
				grp_alu_r, grp_alu_d8:
				begin
					wr_en = (opc[5:3] != 3'd7);	// CP keeps A
					wr_sel = a;
					wr_data = alu_result;
					f_next = alu_flags;
				end
				grp_inc_dec:
				begin
					wr_en = 1'b1;
					wr_data = alu_result;
					f_next = alu_flags;
				end
				grp_cpl:
				begin
					wr_en = 1'b1;
					wr_sel = a;
					wr_data = alu_result;
					f_next[flag_n] = alu_flags[flag_n];	// Z and C kept
					f_next[flag_h] = alu_flags[flag_h];
				end
				grp_scf, grp_ccf:
				begin
					f_next[flag_n] = 1'b0;
					f_next[flag_h] = 1'b0;
					f_next[flag_c] = (grp == grp_scf) || !f[flag_c];
				end
				default: ;	// NOP, JP, JR
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= ifetch;
			pc <= reset_pc;
			f <= 4'h0;
		end
		else
		begin
			if ((bus.phase == ph_strobe) && (state inside {ifetch, imml_fetch, immh_fetch}))
				pc <= add16;
			if (release_ph)
			begin
				state <= next_state;
				f <= f_next;
				if (state == jump)
					pc <= (grp == grp_jp) ? {immh, imml} : add16;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (release_ph)
		begin
			case (state)
				ifetch: op <= bus.rdata;
				imml_fetch: imml <= bus.rdata;
				immh_fetch: immh <= bus.rdata;
				default: ;
			endcase
		end
	end

endmodule

//--- flist.f
bus_pkg.sv
isa_pkg.sv
cpu_bus_if.sv
bus_sequencer.sv
reg_file.sv
alu8.sv
cpu_control.sv
gb_cpu_top.sv
tb_gb_cpu.sv

//--- gb_cpu_top.sv
module gb_cpu_top #(
	parameter bus_pkg::addr_t reset_pc = 16'h0000
) (
	input logic clk, reset,
	input bus_pkg::data_t din,
	output bus_pkg::addr_t adr,
	output bus_pkg::data_t dout,
	output logic ddrv, read, write,
	output bus_pkg::addr_t pc,
	output logic [3:0] f
);
	import isa_pkg::*;
	import bus_pkg::*;

	// Register file port
	logic wr_en, pair_wr_en;
	reg_idx_e wr_sel, rd_sel_src, rd_sel_dst;
	data_t wr_data, src, dst, acc;
	logic [1:0] pair_sel;
	addr_t pair_data, hl;

	// ALU port
	alu_op_e alu_op;
	data_t alu_a, alu_b, alu_result;
	logic alu_carry;
	logic [3:0] alu_flags;

	cpu_bus_if bus ();

	bus_sequencer u_seq (
		.clk(clk), .reset(reset), .din(din), .adr(adr), .dout(dout),
		.ddrv(ddrv), .read(read), .write(write), .bus(bus)
	);

	cpu_control #(.reset_pc(reset_pc)) u_ctrl (
		.clk(clk), .reset(reset), .bus(bus),
		.wr_en(wr_en), .wr_sel(wr_sel), .wr_data(wr_data),
		.pair_wr_en(pair_wr_en), .pair_sel(pair_sel), .pair_data(pair_data),
		.rd_sel_src(rd_sel_src), .rd_sel_dst(rd_sel_dst),
		.src(src), .dst(dst), .acc(acc), .hl(hl),
		.alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b), .alu_carry(alu_carry),
		.alu_result(alu_result), .alu_flags(alu_flags),
		.pc(pc), .f(f)
	);

	reg_file u_regs (
		.clk(clk), .reset(reset),
		.wr_en(wr_en), .wr_sel(wr_sel), .wr_data(wr_data),
		.pair_wr_en(pair_wr_en), .pair_sel(pair_sel), .pair_data(pair_data),
		.rd_sel_src(rd_sel_src), .rd_sel_dst(rd_sel_dst),
		.src(src), .dst(dst), .acc(acc), .hl(hl)
	);

	alu8 u_alu (
		.op(alu_op), .a_in(alu_a), .b_in(alu_b), .carry_in(alu_carry),
		.result(alu_result), .flags(alu_flags)
	);

endmodule

//--- isa_pkg.sv
package isa_pkg;

	// ----------------------------------------
	// Decoded instruction classes
	// ----------------------------------------
	typedef enum logic [3:0] {
		grp_nop,		// Also any opcode outside this core
		grp_ld_r_r,		// LD r,r' / LD r,(HL) / LD (HL),r
		grp_ld_r_d8,
		grp_ld_rr_d16,	// BC, DE, HL
		grp_alu_r,		// ALU op with register or (HL)
		grp_alu_d8,		// ALU op with immediate
		grp_inc_dec,
		grp_cpl,
		grp_scf,
		grp_ccf,
		grp_jp,			// JP a16 and JP cc,a16
		grp_jr			// JR e8 and JR cc,e8
	} op_group_e;

	// ALU operations, first eight in opcode bits 5:3 order
	typedef enum logic [3:0] {
		add, adc, sub, sbc, and_op, xor_op, or_op, cp,
		inc, dec, cpl
	} alu_op_e;

	// Register field encoding of the opcode
	typedef enum logic [2:0] {
		b, c, d, e, h, l, mem_hl, a
	} reg_idx_e;

	// Bit positions inside the F nibble
	localparam int flag_z = 3;
	localparam int flag_n = 2;	// Last op was a subtract
	localparam int flag_h = 1;	// Half carry
	localparam int flag_c = 0;

endpackage

//--- reg_file.sv
module reg_file (
	input logic clk, reset,
	input logic wr_en,
	input isa_pkg::reg_idx_e wr_sel,
	input bus_pkg::data_t wr_data,
	input logic pair_wr_en,
	input logic [1:0] pair_sel,	// 0 BC, 1 DE, 2 HL
	input bus_pkg::addr_t pair_data,
	input isa_pkg::reg_idx_e rd_sel_src, rd_sel_dst,
	output bus_pkg::data_t src, dst, acc,
	output bus_pkg::addr_t hl
);
	import isa_pkg::*;
	import bus_pkg::*;

	data_t reg_b, reg_c, reg_d, reg_e, reg_h, reg_l, reg_a;

	// Byte read by opcode field
	function automatic data_t pick(reg_idx_e idx);
		case (idx)
			b: return reg_b;
			c: return reg_c;
			d: return reg_d;
			e: return reg_e;
			h: return reg_h;
			l: return reg_l;
			a: return reg_a;
			default: return 8'h00;	// (HL) operand comes from the bus
		endcase
	endfunction

	always_comb
	begin
		src = pick(rd_sel_src);
		dst = pick(rd_sel_dst);
	end

	assign acc = reg_a;
	assign hl = {reg_h, reg_l};	// Memory pointer

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			{reg_b, reg_c, reg_d, reg_e} <= '0;
			{reg_h, reg_l, reg_a} <= '0;
		end
		else if (pair_wr_en)
		begin
			case (pair_sel)
				2'd0: {reg_b, reg_c} <= pair_data;
				2'd1: {reg_d, reg_e} <= pair_data;
				2'd2: {reg_h, reg_l} <= pair_data;
				default: ;	// No SP in this core
			endcase
		end
		else if (wr_en)
		begin
			case (wr_sel)
				b: reg_b <= wr_data;
				c: reg_c <= wr_data;
				d: reg_d <= wr_data;
				e: reg_e <= wr_data;
				h: reg_h <= wr_data;
				l: reg_l <= wr_data;
				a: reg_a <= wr_data;
				default: ;	// Stores to (HL) go out on the bus
			endcase
		end
	end

endmodule

//--- tb_gb_cpu.sv
module tb_gb_cpu;
	timeunit 1ns;
	timeprecision 100ps;

	import bus_pkg::*;
	import isa_pkg::*;

	localparam int num_tests = 18;
	localparam int reset_cycles = 8;
	localparam int instr_max = 12;						// Program bytes and instruction bound
	localparam int test_cycles = instr_max * 4 * 4;		// Machine cycles of 4 clocks each
	localparam int max_cycles = num_tests * (test_cycles + reset_cycles + 2);
	localparam addr_t start_pc = 16'h0000;				// Programs sit at address 0

	logic clk, reset;
	data_t din, dout;
	addr_t adr, pc;
	logic ddrv, read, write;
	logic [3:0] f;

	data_t mem [256];		// Program and data memory
	int cycle_cnt = 0;
	int n_added = 0;
	int pass_cnt = 0;
	int fail_cnt = 0;
	int test_errs;
	string cur_name;

	// Test table
	string names [num_tests];
	logic [95:0] progs [num_tests];	// Byte 0 in the top bits
	addr_t st_adrs [num_tests];
	data_t st_dats [num_tests];
	logic [3:0] flags_exp [num_tests];
	addr_t pcs_exp [num_tests];		// Address of the opcode after the store

	gb_cpu_top #(.reset_pc(start_pc)) dut (
		.clk(clk), .reset(reset), .din(din), .adr(adr), .dout(dout),
		.ddrv(ddrv), .read(read), .write(write), .pc(pc), .f(f)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Memory answers from the latched address while the CPU leaves the data bus free
	always @(posedge clk)
		din <= ddrv ? 8'hff : mem[adr[7:0]];

	always @(posedge clk)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > max_cycles)
		begin
			$display("Run stopped, cycle limit of %0d reached", max_cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	// ----------------------------------------
	// Table and checks
	// ----------------------------------------
	task automatic add_test(input string name, input logic [95:0] prog, input addr_t st_adr,
		input data_t st_dat, input logic [3:0] fl, input addr_t next_pc);
		names[n_added] = name;
		progs[n_added] = prog;
		st_adrs[n_added] = st_adr;
		st_dats[n_added] = st_dat;
		flags_exp[n_added] = fl;
		pcs_exp[n_added] = next_pc;
		n_added++;
	endtask

	function automatic string flag_text(logic [3:0] v);
		return $sformatf("%c%c%c%c", v[flag_z] ? "Z" : "-", v[flag_n] ? "N" : "-",
			v[flag_h] ? "H" : "-", v[flag_c] ? "C" : "-");
	endfunction

	task automatic check_data(input string what, input data_t exp, input data_t act);
		if (act !== exp)
		begin
			$display("** Error: %s: %s expected %h, got %h", cur_name, what, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_addr(input string what, input addr_t exp, input addr_t act);
		if (act !== exp)
		begin
			$display("** Error: %s: %s expected %h, got %h", cur_name, what, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_flags(input logic [3:0] exp, input logic [3:0] act);
		if (act !== exp)
		begin
			$display("** Error: %s: F expected %s, got %s", cur_name,
				flag_text(exp), flag_text(act));
			test_errs++;
		end
	endtask

	// ----------------------------------------
	// Reset, load and run one entry
	// ----------------------------------------
	task automatic apply_reset(input logic [95:0] prog);
		int i;
		@(posedge clk);
		reset <= 1'b1;
		for (i = 0; i < 256; i++)
			mem[i] = i[7:0] ^ 8'ha5;	// Background fill
		for (i = 0; i < instr_max; i++)
			mem[i] = prog[95 - 8 * i -: 8];
		repeat (reset_cycles) @(posedge clk);
		reset <= 1'b0;
	endtask

	task automatic run_one(input int t);
		int cyc;
		logic seen_wr, fetched;
		addr_t wr_adr;
		data_t wr_dat;
		cyc = 0;
		seen_wr = 1'b0;
		fetched = 1'b0;
		wr_adr = '0;
		wr_dat = '0;
		cur_name = names[t];
		test_errs = 0;
		apply_reset(progs[t]);
		@(negedge clk);
		check_addr("pc after reset", start_pc, pc);
		if (read || write || ddrv)
		begin
			$display("%s: bus strobes are not low after reset", cur_name);
			test_errs++;
		end
		while (!fetched && (cyc < test_cycles))
		begin
			@(negedge clk);		// Mid clock with outputs settled
			cyc++;
			if (!seen_wr && write)
			begin
				seen_wr = 1'b1;
				wr_adr = adr;
				wr_dat = dout;
			end
			else if (seen_wr && read)
				fetched = 1'b1;	// Next opcode fetch has begun
		end
		if (!seen_wr)
		begin
			$display("%s: no store reached the bus within %0d clocks", cur_name, test_cycles);
			test_errs++;
		end
		else if (!fetched)
		begin
			$display("%s: no opcode fetch followed the store", cur_name);
			test_errs++;
		end
		else
		begin
			check_addr("store address", st_adrs[t], wr_adr);
			check_data("store byte", st_dats[t], wr_dat);
			check_flags(flags_exp[t], f);
			check_addr("fetch address", pcs_exp[t], adr);
			check_addr("pc", pcs_exp[t] + 16'd1, pc);	// Stepped at ph_strobe of the fetch
		end
		if (test_errs == 0)
		begin
			$display("test %s: ok", cur_name);
			pass_cnt++;
		end
		else
		begin
			$display("test %s: %0d mismatches", cur_name, test_errs);
			fail_cnt++;
		end
	endtask

	// Name, program from address 0, store address, store byte, F as ZNHC, next opcode
	task automatic fill_table();
		add_test("ld_moves", 96'h3e5c4748_51218000_72000000, 'h0080, 'h5c, 'b0000, 'h0009);
		add_test("add_carry", 96'h3ef80609_80219000_77000000, 'h0090, 'h01, 'b0011, 'h0009);
		add_test("adc_imm", 96'h373e3ace_05219100_77000000, 'h0091, 'h40, 'b0010, 'h0009);
		add_test("sub_borrow", 96'h3e10d620_21920077_00000000, 'h0092, 'hf0, 'b0101, 'h0008);
		add_test("sbc_reg", 96'h3e05d606_0e0f9921_93007700, 'h0093, 'hef, 'b0110, 'h000b);
		add_test("logic_zero", 96'h3ef0e63c_f60fee3f_21940077, 'h0094, 'h00, 'b1000, 'h000c);
		add_test("and_half", 96'h3eca060f_a0219500_77000000, 'h0095, 'h0a, 'b0010, 'h0009);
		add_test("cp_keeps_a", 96'h3e420650_b8219600_77000000, 'h0096, 'h42, 'b0101, 'h0009);
		add_test("mem_operand", 96'h210b007e_86770000_0000009c, 'h000b, 'h38, 'b0011, 'h0006);
		add_test("inc_wrap", 96'h06ff3704_21970070_00000000, 'h0097, 'h00, 'b1011, 'h0008);
		add_test("dec_wrap", 96'h1e001d21_98007300_00000000, 'h0098, 'hff, 'b0110, 'h0007);
		add_test("cpl_scf", 96'h3e35372f_21990077_00000000, 'h0099, 'hca, 'b0111, 'h0008);
		add_test("ccf_zero", 96'haf3f219a_00770000_00000000, 'h009a, 'h00, 'b1001, 'h0006);
		add_test("jp_z_taken", 96'h219b00af_ca090077_00750000, 'h009b, 'h9b, 'b1000, 'h000a);
		add_test("jp_c_skip", 96'h219c00da_09007500_00770000, 'h009c, 'h9c, 'b0000, 'h0007);
		add_test("jr_nc_fwd", 96'h219d0030_01777500_00000000, 'h009d, 'h9d, 'b0000, 'h0007);
		add_test("jr_nz_loop", 96'h219e0006_030c0520_fc710000, 'h009e, 'h03, 'b1100, 'h000a);
		add_test("jr_jp_plain", 96'h219f0018_027777c3_0b007775, 'h009f, 'h9f, 'b0000, 'h000c);
	endtask

	initial
	begin
		reset = 1'b1;
		din = '0;
		fill_table();
		for (int t = 0; t < num_tests; t++)
			run_one(t);
		$display("Tests run %0d, passed %0d, failed %0d", num_tests, pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule
